// ==== hw/cf_params.svh ====
/* control-flow resolver widths and buffer sizing
   shared by every stage of the pipeline */

`ifndef CF_PARAMS_SVH
`define CF_PARAMS_SVH

// data and address width, one rv32 word
`define CF_XLEN 32

// operation buffer between decoder and judge
`define CF_FIFO_DEPTH 4

// pointer width, log2 of the depth
`define CF_DEPTH_W 2

`endif

// ==== hw/cf_pkg.sv ====
/* control-flow resolver types
   base opcodes and the decoded operation set */

`default_nettype none

package cf_pkg;

    // rv32 base opcodes handled here, everything else decodes to none
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } rv_opcode_e;

    // decoded operation, carried decoder -> fifo -> judge
    typedef enum logic [3:0] {
        OP_NONE,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC
    } cf_op_e;

endpackage

`default_nettype wire

// ==== hw/cf_decoder.sv ====
/* cf_decoder: classifies control-flow instructions, extracts the
   matching immediate and holds the result in a one-entry output register */

`timescale 1ns/10ps
`default_nettype none
`include "cf_params.svh"

module cf_decoder
    import cf_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n_i,
    // instruction stream in
    input  wire                 in_valid_i,
    output logic                in_ready_o,
    input  wire  [`CF_XLEN-1:0] in_pc_i,
    input  wire  [`CF_XLEN-1:0] in_inst_i,
    input  wire  [`CF_XLEN-1:0] in_rs1_i,
    input  wire  [`CF_XLEN-1:0] in_rs2_i,
    // decoded stream out
    output logic                dec_valid_o,
    input  wire                 dec_ready_i,
    output cf_op_e              dec_op_o,
    output logic [`CF_XLEN-1:0] dec_pc_o,
    output logic [`CF_XLEN-1:0] dec_imm_o,
    output logic [`CF_XLEN-1:0] dec_rs1_o,
    output logic [`CF_XLEN-1:0] dec_rs2_o
);

    rv_opcode_e          opcode;
    logic [2:0]          funct3;
    cf_op_e              op_nxt;
    logic [`CF_XLEN-1:0] imm_b, imm_j, imm_i, imm_u;
    logic [`CF_XLEN-1:0] imm_nxt;
    logic                in_fire;

    assign opcode = rv_opcode_e'(in_inst_i[6:0]);
    assign funct3 = in_inst_i[14:12];

    // sign-extended immediates, all formats in parallel
    assign imm_b = {{(`CF_XLEN-12){in_inst_i[31]}}, in_inst_i[7], in_inst_i[30:25],
                    in_inst_i[11:8], 1'b0};
    assign imm_j = {{(`CF_XLEN-20){in_inst_i[31]}}, in_inst_i[19:12], in_inst_i[20],
                    in_inst_i[30:21], 1'b0};
    assign imm_i = {{(`CF_XLEN-11){in_inst_i[31]}}, in_inst_i[30:20]};   // jalr offset
    assign imm_u = {in_inst_i[31:12], 12'b0};                             // lui / auipc

    always_comb begin
        op_nxt = OP_NONE;
        case (opcode)
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op_nxt = OP_BEQ;
                    3'b001:  op_nxt = OP_BNE;
                    3'b100:  op_nxt = OP_BLT;
                    3'b101:  op_nxt = OP_BGE;
                    3'b110:  op_nxt = OP_BLTU;
                    3'b111:  op_nxt = OP_BGEU;
                    default: op_nxt = OP_NONE;   // 010 / 011 reserved
                endcase
            end
            OPC_JAL:   op_nxt = OP_JAL;
            OPC_JALR:  op_nxt = OP_JALR;
            OPC_LUI:   op_nxt = OP_LUI;
            OPC_AUIPC: op_nxt = OP_AUIPC;
            default:   op_nxt = OP_NONE;        // alu, load, store ...
        endcase
    end

    // immediate follows the decoded format
    always_comb begin
        case (op_nxt)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: imm_nxt = imm_b;
            OP_JAL:             imm_nxt = imm_j;
            OP_JALR:            imm_nxt = imm_i;
            OP_LUI, OP_AUIPC:   imm_nxt = imm_u;
            default:            imm_nxt = '0;
        endcase
    end

    // free slot, or the held word leaves this cycle
    assign in_ready_o = !dec_valid_o || dec_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
        end else if (in_fire) begin
            dec_valid_o <= 1'b1;
        end else if (dec_ready_i) begin
            dec_valid_o <= 1'b0;   // drained
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            dec_op_o  <= op_nxt;
            dec_pc_o  <= in_pc_i;
            dec_imm_o <= imm_nxt;
            dec_rs1_o <= in_rs1_i;
            dec_rs2_o <= in_rs2_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cf_op_fifo.sv ====
/* cf_op_fifo: in-order circular buffer for decoded operations,
   registered output, no fall-through */

`timescale 1ns/10ps
`default_nettype none
`include "cf_params.svh"

module cf_op_fifo
    import cf_pkg::*;
#(
    parameter int DEPTH = `CF_FIFO_DEPTH   // power of two, matches CF_DEPTH_W
) (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire                 wr_valid_i,
    output logic                wr_ready_o,
    input  cf_op_e              wr_op_i,
    input  wire  [`CF_XLEN-1:0] wr_pc_i,
    input  wire  [`CF_XLEN-1:0] wr_imm_i,
    input  wire  [`CF_XLEN-1:0] wr_rs1_i,
    input  wire  [`CF_XLEN-1:0] wr_rs2_i,
    output logic                rd_valid_o,
    input  wire                 rd_ready_i,
    output cf_op_e              rd_op_o,
    output logic [`CF_XLEN-1:0] rd_pc_o,
    output logic [`CF_XLEN-1:0] rd_imm_o,
    output logic [`CF_XLEN-1:0] rd_rs1_o,
    output logic [`CF_XLEN-1:0] rd_rs2_o
);

    localparam int OP_W   = $bits(cf_op_e);
    localparam int WORD_W = OP_W + 4*`CF_XLEN;       // op, pc, imm, rs1, rs2
    localparam logic [`CF_DEPTH_W:0] FULL_CNT = DEPTH[`CF_DEPTH_W:0];

    logic [WORD_W-1:0]     mem [DEPTH];
    logic [WORD_W-1:0]     wr_word, rd_word;
    logic [`CF_DEPTH_W-1:0] wr_ptr, rd_ptr;          // wrap naturally
    logic [`CF_DEPTH_W:0]   count;
    logic                  full, empty, wr_fire, rd_fire;

    assign full    = (count == FULL_CNT);
    assign empty   = (count == '0);
    assign wr_fire = wr_valid_i && !full;
    assign rd_fire = rd_ready_i && !empty;

    assign wr_ready_o = !full;    // no read-through when full
    assign rd_valid_o = !empty;

    assign wr_word  = {wr_op_i, wr_pc_i, wr_imm_i, wr_rs1_i, wr_rs2_i};
    assign rd_word  = mem[rd_ptr];
    assign rd_op_o  = cf_op_e'(rd_word[WORD_W-1 -: OP_W]);
    assign rd_pc_o  = rd_word[4*`CF_XLEN-1 -: `CF_XLEN];
    assign rd_imm_o = rd_word[3*`CF_XLEN-1 -: `CF_XLEN];
    assign rd_rs1_o = rd_word[2*`CF_XLEN-1 -: `CF_XLEN];
    assign rd_rs2_o = rd_word[`CF_XLEN-1:0];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
            if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push+pop
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/cf_judge.sv ====
/* cf_judge: resolves branch conditions, computes next pc and
   write-back value, one output register */

`timescale 1ns/10ps
`default_nettype none
`include "cf_params.svh"

module cf_judge
    import cf_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n_i,
    // decoded operation in
    input  wire                 op_valid_i,
    output logic                op_ready_o,
    input  cf_op_e              op_i,
    input  wire  [`CF_XLEN-1:0] pc_i,
    input  wire  [`CF_XLEN-1:0] imm_i,
    input  wire  [`CF_XLEN-1:0] rs1_i,
    input  wire  [`CF_XLEN-1:0] rs2_i,
    // resolved result out
    output logic                out_valid_o,
    input  wire                 out_ready_i,
    output logic [`CF_XLEN-1:0] out_pc_o,
    output logic                out_redirect_o,
    output logic [`CF_XLEN-1:0] out_next_pc_o,
    output logic                out_wb_en_o,
    output logic [`CF_XLEN-1:0] out_wb_data_o
);

    localparam logic [`CF_XLEN-1:0] INST_BYTES = 4;

    logic                eq, lt_s, lt_u, taken;
    logic [`CF_XLEN-1:0] seq_pc, target, jalr_sum;
    logic                redirect_nxt, wb_en_nxt;
    logic [`CF_XLEN-1:0] next_pc_nxt, wb_data_nxt;
    logic                op_fire;

    // operand compare
    assign eq   = (rs1_i == rs2_i);
    assign lt_s = ($signed(rs1_i) < $signed(rs2_i));
    assign lt_u = (rs1_i < rs2_i);

    assign seq_pc   = pc_i + INST_BYTES;
    assign target   = pc_i + imm_i;   // branch, jal and auipc share it
    assign jalr_sum = rs1_i + imm_i;

    always_comb begin
        case (op_i)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        // branch / none defaults
        redirect_nxt = taken;
        next_pc_nxt  = taken ? target : seq_pc;
        wb_en_nxt    = 1'b0;
        wb_data_nxt  = '0;
        case (op_i)
            OP_JAL: begin
                redirect_nxt = 1'b1;
                next_pc_nxt  = target;
                wb_en_nxt    = 1'b1;
                wb_data_nxt  = seq_pc;   // link
            end
            OP_JALR: begin
                redirect_nxt = 1'b1;
                next_pc_nxt  = {jalr_sum[`CF_XLEN-1:1], 1'b0};   // lsb cleared
                wb_en_nxt    = 1'b1;
                wb_data_nxt  = seq_pc;
            end
            OP_LUI: begin
                wb_en_nxt   = 1'b1;
                wb_data_nxt = imm_i;
            end
            OP_AUIPC: begin
                wb_en_nxt   = 1'b1;
                wb_data_nxt = target;
            end
            default: ;
        endcase
    end

    assign op_ready_o = !out_valid_o || out_ready_i;
    assign op_fire    = op_valid_i && op_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (op_fire) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            out_pc_o       <= pc_i;
            out_redirect_o <= redirect_nxt;
            out_next_pc_o  <= next_pc_nxt;
            out_wb_en_o    <= wb_en_nxt;
            out_wb_data_o  <= wb_data_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cf_resolver_top.sv ====
/* cf_resolver_top: decoder, operation FIFO and judge in a chain */

`timescale 1ns/10ps
`default_nettype none
`include "cf_params.svh"

module cf_resolver_top
    import cf_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire                 in_valid_i,
    output logic                in_ready_o,
    input  wire  [`CF_XLEN-1:0] in_pc_i,
    input  wire  [`CF_XLEN-1:0] in_inst_i,
    input  wire  [`CF_XLEN-1:0] in_rs1_i,
    input  wire  [`CF_XLEN-1:0] in_rs2_i,
    output logic                out_valid_o,
    input  wire                 out_ready_i,
    output logic [`CF_XLEN-1:0] out_pc_o,
    output logic                out_redirect_o,
    output logic [`CF_XLEN-1:0] out_next_pc_o,
    output logic                out_wb_en_o,
    output logic [`CF_XLEN-1:0] out_wb_data_o
);

    // decoder -> fifo
    logic                dec_valid, dec_ready;
    cf_op_e              dec_op;
    logic [`CF_XLEN-1:0] dec_pc, dec_imm, dec_rs1, dec_rs2;
    // fifo -> judge
    logic                fifo_valid, fifo_ready;
    cf_op_e              fifo_op;
    logic [`CF_XLEN-1:0] fifo_pc, fifo_imm, fifo_rs1, fifo_rs2;

    cf_decoder u_decoder (
        .clk(clk), .rst_n_i(rst_n_i),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_pc_i(in_pc_i),
        .in_inst_i(in_inst_i), .in_rs1_i(in_rs1_i), .in_rs2_i(in_rs2_i),
        .dec_valid_o(dec_valid), .dec_ready_i(dec_ready), .dec_op_o(dec_op),
        .dec_pc_o(dec_pc), .dec_imm_o(dec_imm), .dec_rs1_o(dec_rs1), .dec_rs2_o(dec_rs2)
    );

    cf_op_fifo #(.DEPTH(`CF_FIFO_DEPTH)) u_fifo (
        .clk(clk), .rst_n_i(rst_n_i),
        .wr_valid_i(dec_valid), .wr_ready_o(dec_ready), .wr_op_i(dec_op),
        .wr_pc_i(dec_pc), .wr_imm_i(dec_imm), .wr_rs1_i(dec_rs1), .wr_rs2_i(dec_rs2),
        .rd_valid_o(fifo_valid), .rd_ready_i(fifo_ready), .rd_op_o(fifo_op),
        .rd_pc_o(fifo_pc), .rd_imm_o(fifo_imm), .rd_rs1_o(fifo_rs1), .rd_rs2_o(fifo_rs2)
    );

    cf_judge u_judge (
        .clk(clk), .rst_n_i(rst_n_i),
        .op_valid_i(fifo_valid), .op_ready_o(fifo_ready), .op_i(fifo_op),
        .pc_i(fifo_pc), .imm_i(fifo_imm), .rs1_i(fifo_rs1), .rs2_i(fifo_rs2),
        .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_pc_o(out_pc_o),
        .out_redirect_o(out_redirect_o), .out_next_pc_o(out_next_pc_o),
        .out_wb_en_o(out_wb_en_o), .out_wb_data_o(out_wb_data_o)
    );

endmodule

`default_nettype wire

// ==== verif/cf_resolver_tb.sv ====
/* control-flow resolver testbench: directed and LFSR-driven instruction
   streams, each result checked in order against a reference model */

`timescale 1ns/10ps
`default_nettype none
`include "cf_params.svh"

module cf_resolver_tb;

    localparam int N_BRANCH  = 30;                   // 6 kinds x 5 operand pairs
    localparam int N_JUMP    = 9;
    localparam int N_MISC    = 6;
    localparam int N_FILL    = `CF_FIFO_DEPTH + 3;   // fill plus the one left waiting
    localparam int N_RAND    = 200;
    localparam int RST_CYC   = 4;
    localparam int WORST_LAT = 16;                   // 3-cycle pipe plus random stalls
    localparam int TIMEOUT   = 2 * (N_BRANCH + N_JUMP + N_MISC + N_FILL + N_RAND)
                               * WORST_LAT + RST_CYC;

    localparam logic [6:0] OPC_BR    = 7'b1100011;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    // equal, signed-less, signed-less only, unsigned-less only, greater
    localparam logic [31:0] OPA [5] = '{32'd5, 32'd3, 32'hfffffff0, 32'd5, 32'd100};
    localparam logic [31:0] OPB [5] = '{32'd5, 32'd9, 32'd5, 32'hfffffff0, 32'd20};
    localparam logic [2:0]  F3S [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rs1;
        logic [31:0] rs2;
    } txn_t;

    typedef struct packed {
        logic        redirect;
        logic [31:0] next_pc;
        logic        wb_en;
        logic        wb_known;   // data defined by the rules
        logic [31:0] wb_data;
    } exp_t;

    logic        clk, rst_n_i;
    logic        in_valid_i, in_ready_o, out_valid_o, out_ready_i;
    logic [31:0] in_pc_i, in_inst_i, in_rs1_i, in_rs2_i;
    logic [31:0] out_pc_o, out_next_pc_o, out_wb_data_o;
    logic        out_redirect_o, out_wb_en_o;

    txn_t        pending [$];    // accepted, not yet resolved
    txn_t        cur;
    exp_t        exp_r;
    logic [31:0] lfsr, pc_next;
    int          errors = 0, checks = 0, n_in = 0, n_out = 0;
    int          tests = 0, failed_tests = 0, err_mark = 0, cycles = 0;

    cf_resolver_top u_dut (
        .clk(clk), .rst_n_i(rst_n_i),
        .in_valid_i(in_valid_i), .in_ready_o(in_ready_o), .in_pc_i(in_pc_i),
        .in_inst_i(in_inst_i), .in_rs1_i(in_rs1_i), .in_rs2_i(in_rs2_i),
        .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .out_pc_o(out_pc_o),
        .out_redirect_o(out_redirect_o), .out_next_pc_o(out_next_pc_o),
        .out_wb_en_o(out_wb_en_o), .out_wb_data_o(out_wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    // expected result straight from the resolution table
    function automatic exp_t cf_expect(input txn_t t);
        exp_t        e;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] seq, b_imm, j_imm, i_imm, u_imm, sum;
        logic        take;
        opc   = t.inst[6:0];
        f3    = t.inst[14:12];
        seq   = t.pc + 32'd4;
        b_imm = {{19{t.inst[31]}}, t.inst[31], t.inst[7], t.inst[30:25], t.inst[11:8], 1'b0};
        j_imm = {{11{t.inst[31]}}, t.inst[31], t.inst[19:12], t.inst[20], t.inst[30:21], 1'b0};
        i_imm = {{20{t.inst[31]}}, t.inst[31:20]};
        u_imm = {t.inst[31:12], 12'h000};
        sum   = t.rs1 + i_imm;
        take  = 1'b0;
        e     = '{1'b0, seq, 1'b0, 1'b0, 32'h0};   // sequential, no write-back
        case (opc)
            OPC_BR: begin
                case (f3)
                    3'b000:  take = (t.rs1 == t.rs2);
                    3'b001:  take = (t.rs1 != t.rs2);
                    3'b100:  take = ($signed(t.rs1) < $signed(t.rs2));
                    3'b101:  take = ($signed(t.rs1) >= $signed(t.rs2));
                    3'b110:  take = (t.rs1 < t.rs2);
                    3'b111:  take = (t.rs1 >= t.rs2);
                    default: e.wb_known = 1'b1;   // reserved funct3, treated as none
                endcase
                if (take) begin
                    e.redirect = 1'b1;
                    e.next_pc  = t.pc + b_imm;
                end
            end
            OPC_JAL:   e = '{1'b1, t.pc + j_imm, 1'b1, 1'b1, seq};
            OPC_JALR:  e = '{1'b1, {sum[31:1], 1'b0}, 1'b1, 1'b1, seq};
            OPC_LUI:   e = '{1'b0, seq, 1'b1, 1'b1, u_imm};
            OPC_AUIPC: e = '{1'b0, seq, 1'b1, 1'b1, t.pc + u_imm};
            default:   e.wb_known = 1'b1;   // none, data zero
        endcase
        return e;
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BR};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd1, OPC_JALR};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm);
        return {imm, 5'd1, opc};
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input logic [31:0] pc);
        if (got !== exp) begin
            $display("mismatch %s at pc %h: got %h expected %h", name, pc, got, exp);
            errors++;
        end
    endtask

    // input capture and in-order output compare
    always @(posedge clk) begin
        if (rst_n_i) begin
            if (in_valid_i && in_ready_o) begin
                pending.push_back(txn_t'({in_pc_i, in_inst_i, in_rs1_i, in_rs2_i}));
                n_in++;
            end
            if (out_valid_o && out_ready_i) begin
                n_out++;
                if (pending.size() == 0) begin
                    $display("result for pc %h came out with no instruction pending", out_pc_o);
                    errors++;
                end else begin
                    cur   = pending.pop_front();
                    exp_r = cf_expect(cur);
                    checks++;
                    check_field("out_pc_o", out_pc_o, cur.pc, cur.pc);
                    check_field("out_redirect_o", 32'(out_redirect_o),
                                32'(exp_r.redirect), cur.pc);
                    check_field("out_next_pc_o", out_next_pc_o, exp_r.next_pc, cur.pc);
                    check_field("out_wb_en_o", 32'(out_wb_en_o), 32'(exp_r.wb_en), cur.pc);
                    if (exp_r.wb_known) begin
                        check_field("out_wb_data_o", out_wb_data_o, exp_r.wb_data, cur.pc);
                    end
                end
            end
        end
    end

    // put one instruction on the input, pc advances by a word
    task automatic present(input logic [31:0] inst, input logic [31:0] rs1,
                           input logic [31:0] rs2);
        in_valid_i = 1'b1;
        in_pc_i    = pc_next;
        in_inst_i  = inst;
        in_rs1_i   = rs1;
        in_rs2_i   = rs2;
        pc_next    = pc_next + 32'd4;
    endtask

    task automatic send(input logic [31:0] inst, input logic [31:0] rs1,
                        input logic [31:0] rs2);
        present(inst, rs1, rs2);
        @(posedge clk);
        while (!in_ready_o) @(posedge clk);
        #2;
        in_valid_i = 1'b0;
    endtask

    task automatic present_random();
        logic [31:0] cls, hi, pcr;
        logic [6:0]  opc;
        cls = take_bits(3);
        case (cls)
            0:       opc = OPC_BR;
            1:       opc = OPC_JAL;
            2:       opc = OPC_JALR;
            3:       opc = OPC_LUI;
            4:       opc = OPC_AUIPC;
            default: opc = 7'(take_bits(7));   // mostly non-control
        endcase
        hi         = take_bits(25);
        pcr        = take_bits(30);
        in_inst_i  = {hi[24:0], opc};
        in_pc_i    = {pcr[29:0], 2'b00};
        in_rs1_i   = take_bits(32);
        in_rs2_i   = take_bits(1) != 0 ? in_rs1_i : take_bits(32);   // equal pairs too
        in_valid_i = 1'b1;
    endtask

    task automatic wait_drain();
        while (pending.size() != 0) @(negedge clk);
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED with %0d errors", tests, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        int   took_cnt;
        int   sent;
        logic took;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        in_pc_i     = '0;
        in_inst_i   = '0;
        in_rs1_i    = '0;
        in_rs2_i    = '0;
        out_ready_i = 1'b1;
        lfsr        = 32'h8133e656;
        pc_next     = 32'h8000_0000;
        repeat (RST_CYC) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        @(posedge clk);
        #2;

        if (out_valid_o !== 1'b0) begin
            $display("out_valid_o is high after reset with no input given");
            errors++;
        end
        if (in_ready_o !== 1'b1) begin
            $display("in_ready_o is low after reset");
            errors++;
        end
        end_test("reset state");

        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 5; p++) begin
                send(enc_b(F3S[k], p[0] ? 13'(-16) : 13'd40), OPA[p], OPB[p]);
            end
        end
        wait_drain();
        end_test("branch conditions");

        send(enc_j(21'd2048), 32'h0, 32'h0);
        send(enc_j(21'(-1024)), 32'h0, 32'h0);
        send(enc_jalr(12'd100), 32'h0000_1000, 32'h0);
        send(enc_jalr(12'(-8)), 32'h0000_2000, 32'h0);
        send(enc_jalr(12'd4), 32'h0000_3001, 32'h0);   // odd target, lsb dropped
        send(enc_u(OPC_LUI, 20'h12345), 32'h0, 32'h0);
        send(enc_u(OPC_LUI, 20'hfedcb), 32'h0, 32'h0);
        send(enc_u(OPC_AUIPC, 20'h00010), 32'h0, 32'h0);
        send(enc_u(OPC_AUIPC, 20'hffff0), 32'h0, 32'h0);
        wait_drain();
        end_test("jumps and upper immediates");

        send(32'h0050_0093, 32'h7, 32'h7);   // addi
        send(32'h0020_81b3, 32'h1, 32'h2);   // add
        send(32'h0000_a103, 32'h100, 32'h0); // lw
        send(32'h0020_a023, 32'h100, 32'h5); // sw
        send(enc_b(3'b010, 13'd8), 32'h3, 32'h3);
        send(enc_b(3'b011, 13'(-8)), 32'h1, 32'h9);
        wait_drain();
        end_test("non-control and reserved branches");

        // back-pressure, pipeline fills then stalls the input
        out_ready_i = 1'b0;
        took_cnt    = 0;
        present(enc_b(3'b001, 13'd8), 32'h0, 32'h3);
        repeat (3 * N_FILL) begin
            @(posedge clk);
            took = in_ready_o;
            #2;
            if (took) begin
                took_cnt++;
                present(enc_b(3'b001, 13'(took_cnt * 8)), 32'(took_cnt), 32'h3);
            end
        end
        if (took_cnt != `CF_FIFO_DEPTH + 2 || in_ready_o !== 1'b0) begin
            $display("pipeline took %0d instructions under back-pressure, expected %0d",
                     took_cnt, `CF_FIFO_DEPTH + 2);
            errors++;
        end
        out_ready_i = 1'b1;
        @(posedge clk);
        while (!in_ready_o) @(posedge clk);
        #2;
        in_valid_i = 1'b0;
        wait_drain();
        end_test("back-pressure fill and release");

        sent = 0;
        while (sent < N_RAND) begin
            out_ready_i = (take_bits(2) != 0);   // ready 3 cycles in 4
            if (!in_valid_i && take_bits(1) != 0) begin
                present_random();
            end
            @(posedge clk);
            took = in_valid_i && in_ready_o;
            #2;
            if (took) begin
                sent++;
                in_valid_i = 1'b0;
            end
        end
        out_ready_i = 1'b1;
        wait_drain();
        end_test("random stream");

        if (n_in != n_out) begin
            $display("%0d instructions went in but %0d results came out", n_in, n_out);
            errors++;
        end
        $display("%0d tests, %0d failed, %0d results checked, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the run did not finish", TIMEOUT);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/cf_pkg.sv
hw/cf_decoder.sv
hw/cf_op_fifo.sv
hw/cf_judge.sv
hw/cf_resolver_top.sv
verif/cf_resolver_tb.sv

// ==== Bender.yml ====
package:
  name: cf_resolver

sources:
  - include_dirs:
      - hw
    files:
      - hw/cf_pkg.sv
      - hw/cf_decoder.sv
      - hw/cf_op_fifo.sv
      - hw/cf_judge.sv
      - hw/cf_resolver_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/cf_resolver_tb.sv
